/* serdes_rx_config.svh */
// Build constants for the SERDES receive path, included by the RTL and the testbench
`ifndef SERDES_RX_CONFIG_SVH
`define SERDES_RX_CONFIG_SVH

// FIFO address width, 9 gives 512 lines
`define SERDES_RX_FIFO_AW 9

// Control characters, K flag set
`define K_COMMA     8'hBC   // K28.5
`define K_IDLE      8'h3C   // K28.1
`define K_PKT_START 8'hDC   // K28.6
`define K_PKT_END   8'h9C   // K28.4
`define K_XON       8'h5C   // K28.2
`define K_XOFF      8'h7C   // K28.3

// Invalid codes from the transceiver
`define K_LOS       8'hFF   // K31.7, loss of signal
`define K_ERROR     8'h00   // K0.0, decode error

// Data byte paired with comma as a pause
`define D_56        8'hC5   // D5.6

`endif

/* serdes_rx_pkg.sv */
// Shared types of the SERDES receive path, referenced by scoped name from every module
`default_nettype none

package serdes_rx_pkg;

   typedef logic [15:0] ser_word_t;    // One halfword off the wire
   typedef logic [17:0] ser_sym_t;     // {k_msb, k_lsb, data}
   typedef logic [31:0] rx_line_t;     // Earlier halfword in [15:0]
   typedef logic [15:0] crc16_t;
   typedef logic [34:0] fifo_word_t;   // {error, sop, eop, line}
   typedef logic [15:0] fifo_count_t;  // Space or occupancy

   // Framer states
   typedef enum logic [2:0]
   {
      IDLE      = 3'd0,  // Armed, waiting for start
      FIRST_LO  = 3'd1,
      FIRST_HI  = 3'd2,
      PKT_LO    = 3'd3,
      PKT_HI    = 3'd4,
      CRC_CHECK = 3'd5,  // Expecting the CRC halfword
      ERROR     = 3'd6,  // Waiting for room for the error entry
      DONE      = 3'd7
   } rx_state_e;

endpackage

`default_nettype wire

/* serdes_rx_aligner.sv */
// Byte-lane realignment of the raw halfword stream, picks the lane pairing at packet start
`timescale 1ns/1ns
`default_nettype none
`include "serdes_rx_config.svh"

module serdes_rx_aligner
(
   input  wire                          ser_rx_clk,
   input  wire                          rst_rxclk,
   input  wire serdes_rx_pkg::ser_sym_t raw_i,    // {k_msb, k_lsb, data}
   input  wire                          arm_i,    // Framer idle
   output serdes_rx_pkg::ser_sym_t      sym_o,
   output logic                         start_o
);

   localparam serdes_rx_pkg::ser_sym_t START_PAIR = {2'b11, `K_PKT_START, `K_PKT_START};

   logic [8:0]              holder_q;   // Last high byte with its K flag
   serdes_rx_pkg::ser_sym_t odd_q;      // Symbol straddling two words
   logic                    odd_sel_q;
   logic                    even_hit;
   logic                    odd_hit;

   always_ff @(posedge ser_rx_clk)
   begin
      if (rst_rxclk)
      begin
         holder_q <= '0;
         odd_q    <= '0;
      end
      else
      begin
         holder_q <= {raw_i[17], raw_i[15:8]};
         // Current low byte becomes the high half
         odd_q    <= {raw_i[16], holder_q[8], raw_i[7:0], holder_q[7:0]};
      end
   end

   assign even_hit = (raw_i == START_PAIR);
   assign odd_hit  = (odd_q == START_PAIR);
   assign start_o  = arm_i && (even_hit || odd_hit);

   // Alignment sticks until the next start, even lane wins a tie
   always_ff @(posedge ser_rx_clk)
   begin
      if (rst_rxclk)
         odd_sel_q <= 1'b0;
      else if (start_o)
         odd_sel_q <= !even_hit;
   end

   assign sym_o = odd_sel_q ? odd_q : raw_i;  // Odd path is one cycle late

   // Only while armed, and the framer must drop arm right after
   a_start_armed: assert property (@(posedge ser_rx_clk) disable iff (rst_rxclk)
      start_o |-> arm_i ##1 !start_o);

endmodule

`default_nettype wire

/* serdes_rx_crc16.sv */
// Running CRC-16-CCITT over payload halfwords, cleared by the framer between packets
`timescale 1ns/1ns
`default_nettype none

module serdes_rx_crc16
(
   input  wire                           ser_rx_clk,
   input  wire                           rst_rxclk,
   input  wire                           clr_i,   // Back to the seed
   input  wire                           upd_i,   // Fold in data_i
   input  wire serdes_rx_pkg::ser_word_t data_i,
   output serdes_rx_pkg::crc16_t         crc_o
);

   // Poly 0x1021, MSB first, all 16 bits in one step
   function automatic serdes_rx_pkg::crc16_t crc_step(input serdes_rx_pkg::crc16_t c,
                                                      input serdes_rx_pkg::ser_word_t d);
      serdes_rx_pkg::crc16_t r;
      logic                  fb;
      r = c;
      for (int i = 15; i >= 0; i--)
      begin
         fb = r[15] ^ d[i];
         r  = {r[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
      end
      return r;
   endfunction

   always_ff @(posedge ser_rx_clk)
   begin
      if (rst_rxclk || clr_i)
         crc_o <= 16'hFFFF;  // Seed
      else if (upd_i)
         crc_o <= crc_step(crc_o, data_i);
   end

endmodule

`default_nettype wire

/* serdes_rx_framer.sv */
// Packet FSM of the receive path, builds lines, checks the CRC and writes the FIFO
`timescale 1ns/1ns
`default_nettype none
`include "serdes_rx_config.svh"

module serdes_rx_framer
(
   input  wire                          ser_rx_clk,
   input  wire                          rst_rxclk,
   input  wire serdes_rx_pkg::ser_sym_t sym_i,        // Aligned symbol
   input  wire                          start_i,
   input  wire serdes_rx_pkg::crc16_t   crc_i,        // CRC so far, before this halfword
   input  wire                          fifo_full_i,
   output logic                         arm_o,
   output logic                         crc_clr_o,
   output logic                         crc_upd_o,
   output logic                         wr_en_o,
   output serdes_rx_pkg::fifo_word_t    wr_data_o     // {error, sop, eop, line}
);

   localparam serdes_rx_pkg::fifo_word_t ERR_WORD = {1'b1, 2'b00, 32'd0};

   serdes_rx_pkg::rx_state_e state_q;
   serdes_rx_pkg::ser_word_t half_q;     // Low half of the line in progress
   serdes_rx_pkg::rx_line_t  pend_line;  // Last complete line, not yet written
   logic                     pend_sop;   // Pending line is the first one
   logic                     is_data;
   logic                     is_pause;
   logic                     is_end;
   logic                     can_wr;

   assign is_data  = (sym_i[17:16] == 2'b00);
   // Flow-control fill, framer just holds
   assign is_pause = (sym_i == {2'b10, `K_COMMA, `D_56}) ||
                     (sym_i == {2'b11, `K_XON, `K_XON}) ||
                     (sym_i == {2'b11, `K_XOFF, `K_XOFF});
   assign is_end   = (sym_i == {2'b11, `K_PKT_END, `K_PKT_END});

   // A write already in flight is not yet counted by the FIFO
   assign can_wr = !fifo_full_i && !wr_en_o;

   assign arm_o     = (state_q == serdes_rx_pkg::IDLE);
   assign crc_clr_o = (state_q == serdes_rx_pkg::IDLE);
   assign crc_upd_o = is_data && (state_q inside {serdes_rx_pkg::FIRST_LO,
                                                  serdes_rx_pkg::FIRST_HI,
                                                  serdes_rx_pkg::PKT_LO,
                                                  serdes_rx_pkg::PKT_HI,
                                                  serdes_rx_pkg::CRC_CHECK});

   always_ff @(posedge ser_rx_clk)
   begin : fsm
      logic fail;
      fail    = 1'b0;
      wr_en_o <= 1'b0;  // Single-cycle strobe
      case (state_q)
         serdes_rx_pkg::IDLE:
            if (start_i)
               state_q <= serdes_rx_pkg::FIRST_LO;
         serdes_rx_pkg::FIRST_LO:
            if (is_data)
            begin
               half_q  <= sym_i[15:0];
               state_q <= serdes_rx_pkg::FIRST_HI;
            end
            else if (!is_pause)
               fail = 1'b1;
         serdes_rx_pkg::FIRST_HI:
            if (is_data)
            begin
               pend_line <= {sym_i[15:0], half_q};  // First line stays pending
               pend_sop  <= 1'b1;
               state_q   <= serdes_rx_pkg::PKT_LO;
            end
            else if (!is_pause)
               fail = 1'b1;
         serdes_rx_pkg::PKT_LO:
            if (is_data)
            begin
               half_q  <= sym_i[15:0];
               state_q <= serdes_rx_pkg::PKT_HI;
            end
            else if (is_end)
               state_q <= serdes_rx_pkg::CRC_CHECK;
            else if (!is_pause)
               fail = 1'b1;
         serdes_rx_pkg::PKT_HI:
            if (is_data && can_wr)
            begin
               // New line done, older one goes out without eop
               wr_en_o   <= 1'b1;
               wr_data_o <= {1'b0, pend_sop, 1'b0, pend_line};
               pend_line <= {sym_i[15:0], half_q};
               pend_sop  <= 1'b0;
               state_q   <= serdes_rx_pkg::PKT_LO;
            end
            else if (is_data || !is_pause)
               fail = 1'b1;  // Full FIFO or stray K
         serdes_rx_pkg::CRC_CHECK:
            if (sym_i == {2'b00, crc_i} && can_wr)
            begin
               wr_en_o   <= 1'b1;
               wr_data_o <= {1'b0, pend_sop, 1'b1, pend_line};
               state_q   <= serdes_rx_pkg::DONE;
            end
            else if (!is_pause)
               fail = 1'b1;  // Bad CRC, no room, or junk
         serdes_rx_pkg::ERROR:
            fail = 1'b1;  // Retry the error entry
         serdes_rx_pkg::DONE:
            state_q <= serdes_rx_pkg::IDLE;
      endcase

      // Pending line is dropped, error entry takes its place
      if (fail)
      begin
         if (can_wr)
         begin
            wr_en_o   <= 1'b1;
            wr_data_o <= ERR_WORD;
            state_q   <= serdes_rx_pkg::IDLE;
         end
         else
            state_q <= serdes_rx_pkg::ERROR;
      end

      if (rst_rxclk)
      begin
         state_q  <= serdes_rx_pkg::IDLE;
         wr_en_o  <= 1'b0;
         pend_sop <= 1'b0;
      end
   end

   // FIFO must still have room when the write lands
   a_no_wr_full: assert property (@(posedge ser_rx_clk) disable iff (rst_rxclk)
      wr_en_o |-> !fifo_full_i);

   a_state_known: assert property (@(posedge ser_rx_clk) disable iff (rst_rxclk)
      !$isunknown(state_q));

   // DONE carries exactly the eop write
   a_done_write: assert property (@(posedge ser_rx_clk) disable iff (rst_rxclk)
      (state_q == serdes_rx_pkg::DONE) |-> wr_en_o && wr_data_o[32] ##1 !wr_en_o);

endmodule

`default_nettype wire

/* serdes_rx_fifo.sv */
// Single-clock show-ahead line FIFO between the framer and the consumer, with counts
`timescale 1ns/1ns
`default_nettype none
`include "serdes_rx_config.svh"

module serdes_rx_fifo
(
   input  wire                            ser_rx_clk,
   input  wire                            rst_rxclk,
   input  wire                            wr_en_i,
   input  wire serdes_rx_pkg::fifo_word_t wr_data_i,
   input  wire                            rd_en_i,     // Consumer ready
   output serdes_rx_pkg::fifo_word_t      rd_data_o,   // Head entry
   output logic                           valid_o,
   output logic                           full_o,
   output logic                           empty_o,
   output serdes_rx_pkg::fifo_count_t     space_o,
   output serdes_rx_pkg::fifo_count_t     occupied_o
);

   localparam int DEPTH = 1 << `SERDES_RX_FIFO_AW;

   serdes_rx_pkg::fifo_word_t     mem [DEPTH];
   logic [`SERDES_RX_FIFO_AW-1:0] wr_ptr_q;
   logic [`SERDES_RX_FIFO_AW-1:0] rd_ptr_q;
   logic                          push;
   logic                          pop;

   assign full_o    = (occupied_o == serdes_rx_pkg::fifo_count_t'(DEPTH));
   assign empty_o   = (occupied_o == '0);
   assign valid_o   = !empty_o;
   assign push      = wr_en_i && !full_o;
   assign pop       = rd_en_i && valid_o;  // Pops when both sides ready
   assign rd_data_o = mem[rd_ptr_q];       // Show-ahead read

   always_ff @(posedge ser_rx_clk)
   begin
      if (push)
         mem[wr_ptr_q] <= wr_data_i;
   end

   always_ff @(posedge ser_rx_clk)
   begin
      if (rst_rxclk)
      begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         occupied_o <= '0;
         space_o    <= serdes_rx_pkg::fifo_count_t'(DEPTH);
      end
      else
      begin
         if (push)
            wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps at depth
         if (pop)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         case ({push, pop})
            2'b10:
            begin
               occupied_o <= occupied_o + 1'b1;
               space_o    <= space_o - 1'b1;
            end
            2'b01:
            begin
               occupied_o <= occupied_o - 1'b1;
               space_o    <= space_o + 1'b1;
            end
            default: ;  // Both or neither, counts hold
         endcase
      end
   end

   // Writer has to respect full
   a_no_overflow: assert property (@(posedge ser_rx_clk) disable iff (rst_rxclk)
      wr_en_i |-> !full_o);

   // Read pointer never runs past the write pointer
   a_no_underflow: assert property (@(posedge ser_rx_clk) disable iff (rst_rxclk)
      empty_o |-> (rd_ptr_q == wr_ptr_q));

   a_count_sum: assert property (@(posedge ser_rx_clk) disable iff (rst_rxclk)
      (space_o + occupied_o) == serdes_rx_pkg::fifo_count_t'(DEPTH));

endmodule

`default_nettype wire

/* serdes_rx_link_mon.sv */
// XON/XOFF strobes and a link-up filter taken straight off the raw received words
`timescale 1ns/1ns
`default_nettype none
`include "serdes_rx_config.svh"

module serdes_rx_link_mon
(
   input  wire                          ser_rx_clk,
   input  wire                          rst_rxclk,
   input  wire serdes_rx_pkg::ser_sym_t raw_i,      // Unaligned input
   output logic                         xon_o,
   output logic                         xoff_o,
   output logic                         link_up_o
);

   logic       good;       // Not an error or LOS pair
   logic [3:0] good_sr;    // [0] newest

   assign good = !((raw_i == {2'b11, `K_ERROR, `K_ERROR}) ||
                   (raw_i == {2'b11, `K_LOS, `K_LOS}));

   always_ff @(posedge ser_rx_clk)
   begin
      if (rst_rxclk)
      begin
         xon_o     <= 1'b0;
         xoff_o    <= 1'b0;
         good_sr   <= '0;
         link_up_o <= 1'b0;
      end
      else
      begin
         // Either lane may carry the flow-control byte
         xon_o     <= ({raw_i[17], raw_i[15:8]} == {1'b1, `K_XON}) ||
                      ({raw_i[16], raw_i[7:0]} == {1'b1, `K_XON});
         xoff_o    <= ({raw_i[17], raw_i[15:8]} == {1'b1, `K_XOFF}) ||
                      ({raw_i[16], raw_i[7:0]} == {1'b1, `K_XOFF});
         good_sr   <= {good_sr[2:0], good};
         link_up_o <= &good_sr[3:1];  // Three oldest must agree
      end
   end

endmodule

`default_nettype wire

/* serdes_rx.sv */
// Top level of the SERDES receive path, wires aligner, CRC, framer, FIFO and link monitor
`timescale 1ns/1ns
`default_nettype none

module serdes_rx
(
   input  wire                           ser_rx_clk,
   input  wire                           rst_rxclk,
   input  wire serdes_rx_pkg::ser_word_t ser_r_i,
   input  wire                           ser_rklsb_i,
   input  wire                           ser_rkmsb_i,
   input  wire                           wr_ready_i,        // Consumer takes the head
   output serdes_rx_pkg::rx_line_t       wr_dat_o,
   output logic [2:0]                    wr_flags_o,        // {error, eop, sop}
   output logic                          wr_ready_o,        // Head entry valid
   output serdes_rx_pkg::fifo_count_t    fifo_space_o,
   output serdes_rx_pkg::fifo_count_t    fifo_occupied_o,
   output logic                          fifo_full_o,
   output logic                          fifo_empty_o,
   output logic                          xon_rcvd_o,
   output logic                          xoff_rcvd_o,
   output logic                          serdes_link_up_o
);

   serdes_rx_pkg::ser_sym_t    raw;
   serdes_rx_pkg::ser_sym_t    sym;
   serdes_rx_pkg::crc16_t      crc;
   serdes_rx_pkg::fifo_word_t  wr_word;
   serdes_rx_pkg::fifo_word_t  rd_word;
   logic                       start;
   logic                       arm;
   logic                       crc_clr;
   logic                       crc_upd;
   logic                       wr_en;

   assign raw = {ser_rkmsb_i, ser_rklsb_i, ser_r_i};

   serdes_rx_aligner i_aligner
   (
      .ser_rx_clk (ser_rx_clk),
      .rst_rxclk  (rst_rxclk),
      .raw_i      (raw),
      .arm_i      (arm),
      .sym_o      (sym),
      .start_o    (start)
   );

   serdes_rx_crc16 i_crc16
   (
      .ser_rx_clk (ser_rx_clk),
      .rst_rxclk  (rst_rxclk),
      .clr_i      (crc_clr),
      .upd_i      (crc_upd),
      .data_i     (sym[15:0]),
      .crc_o      (crc)
   );

   serdes_rx_framer i_framer
   (
      .ser_rx_clk  (ser_rx_clk),
      .rst_rxclk   (rst_rxclk),
      .sym_i       (sym),
      .start_i     (start),
      .crc_i       (crc),
      .fifo_full_i (fifo_full_o),
      .arm_o       (arm),
      .crc_clr_o   (crc_clr),
      .crc_upd_o   (crc_upd),
      .wr_en_o     (wr_en),
      .wr_data_o   (wr_word)
   );

   serdes_rx_fifo i_fifo
   (
      .ser_rx_clk (ser_rx_clk),
      .rst_rxclk  (rst_rxclk),
      .wr_en_i    (wr_en),
      .wr_data_i  (wr_word),
      .rd_en_i    (wr_ready_i),
      .rd_data_o  (rd_word),
      .valid_o    (wr_ready_o),
      .full_o     (fifo_full_o),
      .empty_o    (fifo_empty_o),
      .space_o    (fifo_space_o),
      .occupied_o (fifo_occupied_o)
   );

   serdes_rx_link_mon i_link_mon
   (
      .ser_rx_clk (ser_rx_clk),
      .rst_rxclk  (rst_rxclk),
      .raw_i      (raw),
      .xon_o      (xon_rcvd_o),
      .xoff_o     (xoff_rcvd_o),
      .link_up_o  (serdes_link_up_o)
   );

   // FIFO word is {error, sop, eop, line}
   assign wr_dat_o   = rd_word[31:0];
   assign wr_flags_o = {rd_word[34], rd_word[32], rd_word[33]};

endmodule

`default_nettype wire

/* serdes_rx_tb.sv */
// Random-packet testbench that runs as simulation top over the SERDES receive path in project.f
`timescale 1ns/1ns
`default_nettype none
`include "serdes_rx_config.svh"

module serdes_rx_tb;

   localparam int          DEPTH    = 1 << `SERDES_RX_FIFO_AW;
   localparam int          SEED     = 42891;
   localparam logic [17:0] IDLE_SYM = {2'b11, `K_IDLE, `K_IDLE};
   localparam logic [17:0] STRAY    = {2'b11, `K_COMMA, `K_COMMA};  // K pair that is no pause

   logic                       ser_rx_clk;
   logic                       rst_rxclk;
   serdes_rx_pkg::ser_word_t   ser_r_i;
   logic                       ser_rklsb_i;
   logic                       ser_rkmsb_i;
   logic                       wr_ready_i;
   serdes_rx_pkg::rx_line_t    wr_dat_o;
   logic [2:0]                 wr_flags_o;          // {error, eop, sop}
   logic                       wr_ready_o;
   serdes_rx_pkg::fifo_count_t fifo_space_o;
   serdes_rx_pkg::fifo_count_t fifo_occupied_o;
   logic                       fifo_full_o;
   logic                       fifo_empty_o;
   logic                       xon_rcvd_o;
   logic                       xoff_rcvd_o;
   logic                       serdes_link_up_o;

   logic [34:0] exp_q[$];    // Expected entries as {flags, line} on the outputs
   logic [8:0]  byte_q[$];   // {k, byte}, oldest first on the wire
   string       test_name;
   int          xon_exp;     // Words carrying an XON byte
   int          xoff_exp;
   int          xon_seen;    // Pulses counted at the output
   int          xoff_seen;

   serdes_rx i_serdes_rx
   (
      .ser_rx_clk       (ser_rx_clk),
      .rst_rxclk        (rst_rxclk),
      .ser_r_i          (ser_r_i),
      .ser_rklsb_i      (ser_rklsb_i),
      .ser_rkmsb_i      (ser_rkmsb_i),
      .wr_ready_i       (wr_ready_i),
      .wr_dat_o         (wr_dat_o),
      .wr_flags_o       (wr_flags_o),
      .wr_ready_o       (wr_ready_o),
      .fifo_space_o     (fifo_space_o),
      .fifo_occupied_o  (fifo_occupied_o),
      .fifo_full_o      (fifo_full_o),
      .fifo_empty_o     (fifo_empty_o),
      .xon_rcvd_o       (xon_rcvd_o),
      .xoff_rcvd_o      (xoff_rcvd_o),
      .serdes_link_up_o (serdes_link_up_o)
   );

   initial
   begin
      ser_rx_clk = 1'b0;
      forever #20 ser_rx_clk = ~ser_rx_clk;  // 40 ns period
   end

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (actual !== expected)
      begin
         $display("MISMATCH %s %s expected %0h actual %0h", test_name, name, expected, actual);
         $display("TESTBENCH FAILED");
         $fatal(1, "Stopped at first error");
      end
   endtask

   task automatic fail_timeout(input string what);
      $display("Timeout in %s while waiting for %s", test_name, what);
      $display("TESTBENCH FAILED");
      $fatal(1, "Stopped on timeout");
   endtask

   // CCITT word form folds the whole halfword into the top then shifts 16 times
   function automatic logic [15:0] crc_next(input logic [15:0] c, input logic [15:0] d);
      logic [15:0] r;
      r = c ^ d;
      repeat (16)
         r = r[15] ? ((r << 1) ^ 16'h1021) : (r << 1);
      return r;
   endfunction

   function automatic int has_k(input logic [8:0] lo, input logic [8:0] hi,
                                input logic [7:0] code);
      return ((lo == {1'b1, code}) || (hi == {1'b1, code})) ? 1 : 0;
   endfunction

   task automatic push_sym(input logic [17:0] s);
      byte_q.push_back({s[16], s[7:0]});   // Low byte goes first
      byte_q.push_back({s[17], s[15:8]});
   endtask

   task automatic maybe_pause();
      case ($urandom % 8)
         0: push_sym({2'b10, `K_COMMA, `D_56});
         1: push_sym({2'b11, `K_XON, `K_XON});
         2: push_sym({2'b11, `K_XOFF, `K_XOFF});
         default: ;
      endcase
   endtask

   // One word per clock from the byte queue with random consumer ready
   task automatic drive_stream();
      logic [8:0] lo;
      logic [8:0] hi;
      if (byte_q.size() % 2 != 0)
         byte_q.push_back({1'b1, `K_IDLE});  // Pad the odd tail
      while (byte_q.size() > 0)
      begin
         lo = byte_q.pop_front();
         hi = byte_q.pop_front();
         @(posedge ser_rx_clk);
         ser_r_i     <= {hi[7:0], lo[7:0]};
         ser_rklsb_i <= lo[8];
         ser_rkmsb_i <= hi[8];
         wr_ready_i  <= ($urandom % 4 != 0);
         xon_exp     += has_k(lo, hi, `K_XON);
         xoff_exp    += has_k(lo, hi, `K_XOFF);
      end
   endtask

   // Mode 0 good, 1 corrupted CRC, 2 stray K symbol mid-packet
   task automatic send_packet(input int mode);
      int          nlines;
      int          cut;     // Halfwords sent before the stray K
      int          nwrit;   // Lines that reach the FIFO
      int          i;
      logic        odd;
      logic [15:0] crc;
      logic [15:0] flip;
      logic [15:0] hw[$];
      nlines = 1 + $urandom % 16;
      cut    = 1 + $urandom % (2 * nlines);
      odd    = 1'($urandom % 2);
      flip   = 16'(1 + $urandom % 65535);    // Never zero
      crc    = 16'hFFFF;
      for (i = 0; i < 2 * nlines; i++)
      begin
         hw.push_back(16'($urandom));
         crc = crc_next(crc, hw[i]);
      end
      if (odd)
         byte_q.push_back({1'b1, `K_IDLE});  // Shift framing by one byte
      push_sym({2'b11, `K_PKT_START, `K_PKT_START});
      i = 0;
      while (i < 2 * nlines && !(mode == 2 && i == cut))
      begin
         maybe_pause();
         push_sym({2'b00, hw[i]});
         i++;
      end
      maybe_pause();
      if (mode == 2)
         push_sym(STRAY);
      else
      begin
         push_sym({2'b11, `K_PKT_END, `K_PKT_END});
         maybe_pause();
         push_sym({2'b00, (mode == 1) ? (crc ^ flip) : crc});
      end
      repeat (4) push_sym(IDLE_SYM);  // Gap lets the framer re-arm
      // Each line waits for the next one and the last needs a good CRC
      nwrit = (mode == 0) ? nlines : (mode == 1) ? nlines - 1 : cut / 2 - 1;
      for (i = 0; i < nwrit; i++)
         exp_q.push_back({1'b0, (mode == 0 && i == nlines - 1), (i == 0),
                          hw[2 * i + 1], hw[2 * i]});
      if (mode != 0)
         exp_q.push_back({3'b100, 32'd0});
      drive_stream();
   endtask

   task automatic wait_link(input logic level, input string what);
      int n;
      n = 0;
      do
      begin
         @(negedge ser_rx_clk);
         n++;
      end
      while (serdes_link_up_o !== level && n < 8);
      if (serdes_link_up_o !== level)
         fail_timeout(what);
   endtask

   // Consumer side sampled mid-cycle where outputs are settled
   always @(negedge ser_rx_clk)
   begin
      if (!rst_rxclk)
      begin
         check_value("space plus occupied", DEPTH, fifo_space_o + fifo_occupied_o);
         if (exp_q.size() < DEPTH)
            check_value("fifo full", 0, fifo_full_o);  // Cannot hold more than outstanding
         if (exp_q.size() == 0)
            check_value("fifo empty", 1, fifo_empty_o);  // Nothing outstanding
         else if (wr_ready_o && wr_ready_i)
            check_value("entry", exp_q.pop_front(), {wr_flags_o, wr_dat_o});
         if (xon_rcvd_o)
            xon_seen++;
         if (xoff_rcvd_o)
            xoff_seen++;
      end
   end

   initial
   begin : stimulus
      int p;
      int n;
      void'($urandom(SEED));
      rst_rxclk   = 1'b1;
      ser_r_i     = {`K_IDLE, `K_IDLE};
      ser_rklsb_i = 1'b1;
      ser_rkmsb_i = 1'b1;
      wr_ready_i  = 1'b0;
      xon_exp     = 0;
      xoff_exp    = 0;
      xon_seen    = 0;
      xoff_seen   = 0;
      test_name   = "reset";
      repeat (3) @(posedge ser_rx_clk);
      rst_rxclk <= 1'b0;
      @(negedge ser_rx_clk);
      check_value("flags after reset", 9'h001, {wr_ready_o, wr_flags_o, xon_rcvd_o,
                  xoff_rcvd_o, serdes_link_up_o, fifo_full_o, fifo_empty_o});
      check_value("counts after reset", {16'(DEPTH), 16'd0}, {fifo_space_o, fifo_occupied_o});

      test_name = "link";
      wait_link(1'b1, "link up after reset");
      push_sym({2'b11, `K_LOS, `K_LOS});
      drive_stream();
      wait_link(1'b0, "link down on LOS");
      push_sym(IDLE_SYM);
      drive_stream();
      wait_link(1'b1, "link up after LOS");
      push_sym({2'b11, `K_ERROR, `K_ERROR});
      drive_stream();
      wait_link(1'b0, "link down on decode error");
      push_sym(IDLE_SYM);
      drive_stream();
      wait_link(1'b1, "link up after decode error");

      // Every bad packet is followed by a good one
      test_name = "packets";
      for (p = 0; p < 60; p++)
         send_packet((p % 6 == 1) ? 1 : (p % 6 == 3) ? 2 : 0);

      test_name = "drain";
      @(posedge ser_rx_clk);
      wr_ready_i <= 1'b1;
      n = 0;
      while (exp_q.size() > 0 && n < 2000)
      begin
         @(posedge ser_rx_clk);
         n++;
      end
      if (exp_q.size() > 0)
         fail_timeout("the FIFO to deliver all expected entries");
      repeat (4) @(negedge ser_rx_clk);
      check_value("empty at end", 1, fifo_empty_o);
      check_value("occupied at end", 0, fifo_occupied_o);
      check_value("xon pulses", xon_exp, xon_seen);
      check_value("xoff pulses", xoff_exp, xoff_seen);
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* project.f */
+incdir+.
serdes_rx_pkg.sv
serdes_rx_aligner.sv
serdes_rx_crc16.sv
serdes_rx_framer.sv
serdes_rx_fifo.sv
serdes_rx_link_mon.sv
serdes_rx.sv
serdes_rx_tb.sv
